/* include/synctimer_consts.svh */
// sync timer constants for timer format, tick rate and command frame layout
`ifndef SYNCTIMER_CONSTS_SVH
`define SYNCTIMER_CONSTS_SVH

// --------------------
// timer format
// --------------------
`define SYNC_TIMER_WIDTH 64

// nanoseconds per clock as num / den
`define SYNC_TICK_NUM 10
`define SYNC_TICK_DEN 3

// --------------------
// frame layout
// --------------------
`define SYNC_INDEX_WIDTH 16     // payload byte index
`define SYNC_CMD_ID_INDEX 0
`define SYNC_TIME_INDEX 1       // timestamp right after the id byte
`define SYNC_TIME_BYTES 8

// per node slots
`define SYNC_SLOT_BASE 9
`define SYNC_SLOT_BYTES 4
`define SYNC_FIRST_NODE 2       // node number owning the first slot

`endif

/* source/synctimer_pkg.sv */
// shared timer, offset and payload byte types for the sync timer slave
`include "synctimer_consts.svh"

package synctimer_pkg;

    // timer value
    typedef logic [`SYNC_TIMER_WIDTH-1:0] time_t;

    typedef logic [31:0] offset_t;     // delay or turnaround
    typedef logic [7:0]  byte_t;

    // --------------------
    // wire formats
    // --------------------
    // little endian, lane 0 is the first byte on the ring
    typedef byte_t [`SYNC_TIME_BYTES-1:0] time_pkt_t;
    typedef byte_t [`SYNC_SLOT_BYTES-1:0] offset_pkt_t;

endpackage

/* source/packet_position.sv */
// byte window detector that flags payload bytes whose index falls in a window set at setup
`timescale 1ns/1ns

module packet_position #(
    parameter int INDEX_WIDTH = 16,
    parameter int FLAG_WIDTH  = 1
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   setup,
    input  logic [INDEX_WIDTH-1:0] index,
    input  logic                   valid,
    input  logic [INDEX_WIDTH-1:0] offset,
    output logic [FLAG_WIDTH-1:0]  flags,
    output logic                   hit
);

    logic [INDEX_WIDTH-1:0] start;     // window start
    logic [INDEX_WIDTH-1:0] rel;

    always_ff @(posedge clk) begin
        if (reset) begin
            start <= '0;
        end else if (setup) begin
            start <= offset;
        end
    end

    assign rel = index - start;

    // one lane per byte of the field
    always_comb begin
        flags = '0;
        for (int i = 0; i < FLAG_WIDTH; i++) begin
            if (valid && index >= start && rel == INDEX_WIDTH'(i)) begin
                flags[i] = 1'b1;
            end
        end
    end

    assign hit = |flags;

    // the window only moves between frames
    assert property (@(posedge clk) disable iff (reset) setup |-> !valid)
        else $error("packet_position: payload byte during window setup");

endmodule

/* source/field_capture.sv */
// field capture, gathers a little endian multi-byte field from the flagged payload bytes
`timescale 1ns/1ns
`include "synctimer_consts.svh"

module field_capture import synctimer_pkg::*; #(
    parameter type field_t = byte_t
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         setup,
    input  logic [`SYNC_INDEX_WIDTH-1:0] index,
    input  logic                         valid,
    input  byte_t                        data,
    input  logic [`SYNC_INDEX_WIDTH-1:0] offset,
    output field_t                       field
);

    localparam int FIELD_BYTES = $bits(field_t) / 8;

    logic  [FIELD_BYTES-1:0] lane_flags;
    byte_t [FIELD_BYTES-1:0] lanes;

    // --------------------
    // byte location
    // --------------------
    packet_position #(
        .INDEX_WIDTH (`SYNC_INDEX_WIDTH),
        .FLAG_WIDTH  (FIELD_BYTES)
    ) i_position (
        .clk    (clk),
        .reset  (reset),
        .setup  (setup),
        .index  (index),
        .valid  (valid),
        .offset (offset),
        .flags  (lane_flags),
        .hit    ()
    );

    // --------------------
    // lane storage
    // --------------------
    always_ff @(posedge clk) begin
        for (int i = 0; i < FIELD_BYTES; i++) begin
            if (lane_flags[i]) begin
                lanes[i] <= data;     // held until the next frame rewrites it
            end
        end
    end

    assign field = field_t'(lanes);

endmodule

/* source/sync_timer.sv */
// local sync timer with fractional tick and step correction, plus an uncorrected free-run timer
`timescale 1ns/1ns
`include "synctimer_consts.svh"

module sync_timer import synctimer_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  time_t   correct_time,
    input  logic    correct_renew,
    input  logic    correct_valid,
    input  offset_t adjust_min,
    input  offset_t adjust_max,
    output time_t   current_time,
    output time_t   free_run_time
);

    localparam int TICK_INT   = `SYNC_TICK_NUM / `SYNC_TICK_DEN;
    localparam int TICK_REM   = `SYNC_TICK_NUM % `SYNC_TICK_DEN;
    localparam int FRAC_WIDTH = $clog2(2 * `SYNC_TICK_DEN);

    // --------------------
    // tick generation
    // --------------------
    logic [FRAC_WIDTH-1:0] frac;
    logic [FRAC_WIDTH-1:0] frac_sum;
    logic                  frac_wrap;
    time_t                 tick;

    assign frac_sum  = frac + FRAC_WIDTH'(TICK_REM);
    assign frac_wrap = frac_sum >= FRAC_WIDTH'(`SYNC_TICK_DEN);
    assign tick      = time_t'(TICK_INT) + time_t'(frac_wrap);    // 3, 3, 4 at 10/3

    always_ff @(posedge clk) begin
        if (reset) begin
            frac <= '0;
        end else if (frac_wrap) begin
            frac <= frac_sum - FRAC_WIDTH'(`SYNC_TICK_DEN);
        end else begin
            frac <= frac_sum;
        end
    end

    // --------------------
    // phase error
    // --------------------
    logic signed [`SYNC_TIMER_WIDTH-1:0] phase_err;
    logic signed [`SYNC_TIMER_WIDTH-1:0] err_min;
    logic signed [`SYNC_TIMER_WIDTH-1:0] err_max;
    logic signed [`SYNC_TIMER_WIDTH-1:0] err_step;

    assign phase_err = signed'(correct_time - current_time);
    assign err_min   = signed'(adjust_min);     // sign extended
    assign err_max   = signed'(adjust_max);

    always_comb begin
        if (phase_err < err_min) begin
            err_step = err_min;
        end else if (phase_err > err_max) begin
            err_step = err_max;
        end else begin
            err_step = phase_err;
        end
    end

    // both timers share the tick, only current_time is corrected
    always_ff @(posedge clk) begin
        if (reset) begin
            current_time  <= '0;
            free_run_time <= '0;
        end else begin
            free_run_time <= free_run_time + tick;
            if (correct_valid && correct_renew) begin
                current_time <= correct_time;
            end else if (correct_valid) begin
                current_time <= current_time + tick + time_t'(err_step);
            end else begin
                current_time <= current_time + tick;
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        (correct_valid && !correct_renew) |-> $signed(adjust_min) <= $signed(adjust_max))
        else $error("sync_timer: step limits inverted during correction");

endmodule

/* source/response_stamper.sv */
// response stamper that writes the command to response turnaround into this node's slot
`timescale 1ns/1ns
`include "synctimer_consts.svh"

module response_stamper import synctimer_pkg::*; (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         cmd_start,
    input  logic                         res_start,
    input  logic                         res_setup,
    input  logic                         res_enable,
    input  logic [`SYNC_INDEX_WIDTH-1:0] res_rx_index,
    input  logic                         res_rx_valid,
    input  logic [`SYNC_INDEX_WIDTH-1:0] slot_pos,
    input  time_t                        free_run_time,
    output byte_t                        res_tx_data,
    output logic                         res_tx_valid
);

    offset_t     start_stamp;
    offset_t     elapsed;
    offset_pkt_t shift_q;
    logic        slot_hit;

    // --------------------
    // turnaround
    // --------------------
    always_ff @(posedge clk) begin
        if (cmd_start) begin
            start_stamp <= offset_t'(free_run_time);
        end
        if (res_start) begin
            elapsed <= offset_t'(free_run_time) - start_stamp;    // wraps at 32 bits
        end
    end

    packet_position #(
        .INDEX_WIDTH (`SYNC_INDEX_WIDTH),
        .FLAG_WIDTH  (`SYNC_SLOT_BYTES)
    ) i_slot_position (
        .clk    (clk),
        .reset  (reset),
        .setup  (res_setup && res_enable),
        .index  (res_rx_index),
        .valid  (res_rx_valid),
        .offset (slot_pos),
        .flags  (),
        .hit    (slot_hit)
    );

    // --------------------
    // slot replacement
    // --------------------
    always_ff @(posedge clk) begin
        if (res_setup && res_enable) begin
            shift_q <= offset_pkt_t'(elapsed);
        end else if (slot_hit) begin
            shift_q <= shift_q >> 8;      // lsb first
        end
        res_tx_data <= shift_q[0];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            res_tx_valid <= 1'b0;
        end else begin
            res_tx_valid <= slot_hit;
        end
    end

    // elapsed has to settle before the slot is loaded
    assert property (@(posedge clk) disable iff (reset)
        (res_setup && res_enable) |-> !res_start)
        else $error("response_stamper: slot loaded in the turnaround stamp cycle");

endmodule

/* source/synctimer_slave.sv */
// sync timer slave top, captures the command frame fields, corrects the timer, stamps responses
`timescale 1ns/1ns
`include "synctimer_consts.svh"

module synctimer_slave import synctimer_pkg::*; (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         adj_enable,
    input  byte_t                        node_self,
    input  offset_t                      adjust_min,
    input  offset_t                      adjust_max,
    // command frame
    input  logic                         cmd_start,
    input  logic                         cmd_setup,
    input  logic                         cmd_finish,
    input  logic                         cmd_fail,
    input  logic                         cmd_enable,
    input  logic [`SYNC_INDEX_WIDTH-1:0] cmd_rx_index,
    input  byte_t                        cmd_rx_data,
    input  logic                         cmd_rx_valid,
    // response frame
    input  logic                         res_start,
    input  logic                         res_setup,
    input  logic                         res_enable,
    input  logic [`SYNC_INDEX_WIDTH-1:0] res_rx_index,
    input  logic                         res_rx_valid,
    output time_t                        current_time,
    output byte_t                        res_tx_data,
    output logic                         res_tx_valid
);

    localparam int IW = `SYNC_INDEX_WIDTH;

    logic          cmd_busy;
    logic [IW-1:0] slot_pos;
    logic          cmd_arm;
    byte_t         cmd_id;
    time_pkt_t     time_pkt;
    offset_pkt_t   offset_pkt;
    time_t         correct_time;
    logic          correct_valid;
    time_t         free_run_time;

    // --------------------
    // command frame tracking
    // --------------------
    assign cmd_arm = cmd_setup && cmd_enable;

    always_ff @(posedge clk) begin
        if (cmd_start) begin
            slot_pos <= IW'(`SYNC_SLOT_BASE)
                + (IW'(node_self) - IW'(`SYNC_FIRST_NODE)) * IW'(`SYNC_SLOT_BYTES);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cmd_busy <= 1'b0;
        end else if (cmd_finish || cmd_fail) begin
            cmd_busy <= 1'b0;
        end else if (cmd_arm) begin
            cmd_busy <= 1'b1;
        end
    end

    field_capture #(.field_t(byte_t)) i_cap_id (
        .clk    (clk),
        .reset  (reset),
        .setup  (cmd_arm),
        .index  (cmd_rx_index),
        .valid  (cmd_rx_valid),
        .data   (cmd_rx_data),
        .offset (IW'(`SYNC_CMD_ID_INDEX)),
        .field  (cmd_id)
    );

    field_capture #(.field_t(time_pkt_t)) i_cap_time (
        .clk    (clk),
        .reset  (reset),
        .setup  (cmd_arm),
        .index  (cmd_rx_index),
        .valid  (cmd_rx_valid),
        .data   (cmd_rx_data),
        .offset (IW'(`SYNC_TIME_INDEX)),
        .field  (time_pkt)
    );

    // this node's delay offset
    field_capture #(.field_t(offset_pkt_t)) i_cap_offset (
        .clk    (clk),
        .reset  (reset),
        .setup  (cmd_arm),
        .index  (cmd_rx_index),
        .valid  (cmd_rx_valid),
        .data   (cmd_rx_data),
        .offset (slot_pos),
        .field  (offset_pkt)
    );

    // --------------------
    // timer correction
    // --------------------
    assign correct_time  = time_t'(time_pkt) + time_t'(offset_t'(offset_pkt));
    assign correct_valid = cmd_finish && cmd_busy && cmd_id[0] && adj_enable;

    sync_timer i_timer (
        .clk           (clk),
        .reset         (reset),
        .correct_time  (correct_time),
        .correct_renew (cmd_id[1]),     // reload instead of step
        .correct_valid (correct_valid),
        .adjust_min    (adjust_min),
        .adjust_max    (adjust_max),
        .current_time  (current_time),
        .free_run_time (free_run_time)
    );

    response_stamper i_stamper (
        .clk           (clk),
        .reset         (reset),
        .cmd_start     (cmd_start),
        .res_start     (res_start),
        .res_setup     (res_setup),
        .res_enable    (res_enable),
        .res_rx_index  (res_rx_index),
        .res_rx_valid  (res_rx_valid),
        .slot_pos      (slot_pos),
        .free_run_time (free_run_time),
        .res_tx_data   (res_tx_data),
        .res_tx_valid  (res_tx_valid)
    );

endmodule

/* test/synctimer_slave_tb.sv */
// testbench for the sync timer slave, command and response frames checked against a reference model
`timescale 1ns/1ns
`include "synctimer_consts.svh"

module synctimer_slave_tb import synctimer_pkg::*; ();

    localparam int IW         = `SYNC_INDEX_WIDTH;
    localparam int NODES      = 8;     // nodes 2 to 9
    localparam int FRAME_LEN  = `SYNC_SLOT_BASE + NODES * `SYNC_SLOT_BYTES;
    localparam int MAX_CYCLES = 4000;  // roughly twice the run length

    logic          clk;
    logic          reset;
    logic          adj_enable;
    byte_t         node_self;
    offset_t       adjust_min;
    offset_t       adjust_max;
    logic          cmd_start;
    logic          cmd_setup;
    logic          cmd_finish;
    logic          cmd_fail;
    logic          cmd_enable;
    logic [IW-1:0] cmd_rx_index;
    byte_t         cmd_rx_data;
    logic          cmd_rx_valid;
    logic          res_start;
    logic          res_setup;
    logic          res_enable;
    logic [IW-1:0] res_rx_index;
    logic          res_rx_valid;
    time_t         current_time;
    byte_t         res_tx_data;
    logic          res_tx_valid;

    // reference model state
    int            m_phase;
    time_t         m_time;
    time_t         m_free;
    offset_t       m_stamp;
    offset_t       m_elapsed;
    byte_t         m_tx_byte;
    logic          fix_now;
    logic          fix_renew;
    time_t         fix_target;
    logic [IW-1:0] exp_slot;
    logic          exp_slot_hit;
    logic          idle_check;

    int errors = 0;
    int errors_at_start = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cycles = 0;

    synctimer_slave i_dut (
        .clk          (clk),
        .reset        (reset),
        .adj_enable   (adj_enable),
        .node_self    (node_self),
        .adjust_min   (adjust_min),
        .adjust_max   (adjust_max),
        .cmd_start    (cmd_start),
        .cmd_setup    (cmd_setup),
        .cmd_finish   (cmd_finish),
        .cmd_fail     (cmd_fail),
        .cmd_enable   (cmd_enable),
        .cmd_rx_index (cmd_rx_index),
        .cmd_rx_data  (cmd_rx_data),
        .cmd_rx_valid (cmd_rx_valid),
        .res_start    (res_start),
        .res_setup    (res_setup),
        .res_enable   (res_enable),
        .res_rx_index (res_rx_index),
        .res_rx_valid (res_rx_valid),
        .current_time (current_time),
        .res_tx_data  (res_tx_data),
        .res_tx_valid (res_tx_valid)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic time_t tick_ns(input int phase);
        return (phase == 2) ? time_t'(4) : time_t'(3);    // 3, 3, 4 ns
    endfunction

    function automatic longint clamp_step(input longint err, input offset_t lo, input offset_t hi);
        longint lo_s;
        longint hi_s;
        lo_s = longint'($signed(lo));
        hi_s = longint'($signed(hi));
        if (err < lo_s) begin
            return lo_s;
        end
        return (err > hi_s) ? hi_s : err;
    endfunction

    function automatic logic [IW-1:0] slot_of(input byte_t node);
        return IW'(`SYNC_SLOT_BASE + (int'(node) - `SYNC_FIRST_NODE) * `SYNC_SLOT_BYTES);
    endfunction

    function automatic byte_t random_node();
        return byte_t'(`SYNC_FIRST_NODE + $urandom % NODES);
    endfunction

    // --------------------
    // reference model
    // --------------------
    assign exp_slot_hit = res_rx_valid && res_rx_index >= exp_slot
                          && res_rx_index < exp_slot + IW'(`SYNC_SLOT_BYTES);

    always @(posedge clk) begin
        if (reset) begin
            m_phase <= 0;
            m_time  <= '0;
            m_free  <= '0;
        end else begin
            m_phase <= (m_phase == 2) ? 0 : m_phase + 1;
            m_free  <= m_free + tick_ns(m_phase);
            if (fix_now && fix_renew) begin
                m_time <= fix_target;
            end else if (fix_now) begin
                m_time <= m_time + tick_ns(m_phase)
                    + time_t'(clamp_step(longint'(fix_target - m_time), adjust_min, adjust_max));
            end else begin
                m_time <= m_time + tick_ns(m_phase);
            end
        end
        if (cmd_start) m_stamp <= offset_t'(m_free);
        if (res_start) m_elapsed <= offset_t'(m_free) - m_stamp;
        if (exp_slot_hit) begin
            m_tx_byte <= byte_t'(m_elapsed >> (8 * (res_rx_index - exp_slot)));
        end
    end

    // --------------------
    // checks
    // --------------------
    timer_matches: assert property (@(posedge clk) disable iff (reset) current_time == m_time)
        else begin
            errors++;
            $display("CHECK FAILED at %0t: current_time %0d, expected %0d", $time,
                     $sampled(current_time), $sampled(m_time));
        end

    idle_rate: assert property (@(posedge clk) disable iff (reset)
        (idle_check && $past(idle_check, `SYNC_TICK_DEN))
        |-> current_time == $past(current_time, `SYNC_TICK_DEN) + time_t'(`SYNC_TICK_NUM))
        else begin
            errors++;
            $display("CHECK FAILED at %0t: timer did not gain %0d ns over %0d clocks", $time,
                     `SYNC_TICK_NUM, `SYNC_TICK_DEN);
        end

    renew_load: assert property (@(posedge clk) disable iff (reset)
        (fix_now && fix_renew) |=> current_time == $past(fix_target))
        else begin
            errors++;
            $display("CHECK FAILED at %0t: reload gave %0d", $time, $sampled(current_time));
        end

    slot_strobe: assert property (@(posedge clk) disable iff (reset)
        res_tx_valid == $past(exp_slot_hit))
        else begin
            errors++;
            $display("CHECK FAILED at %0t: res_tx_valid is %0b", $time, $sampled(res_tx_valid));
        end

    slot_data: assert property (@(posedge clk) disable iff (reset)
        res_tx_valid |-> res_tx_data == m_tx_byte)
        else begin
            errors++;
            $display("CHECK FAILED at %0t: res_tx_data %h, expected %h", $time,
                     $sampled(res_tx_data), $sampled(m_tx_byte));
        end

    // --------------------
    // stimulus
    // --------------------
    task automatic send_command(input byte_t node, input byte_t id, input time_t stamp,
                                input offset_t offs, input logic enable, input logic fail,
                                input int gap);
        byte_t         frame [FRAME_LEN];
        logic [IW-1:0] slot;
        slot = slot_of(node);
        for (int i = 0; i < FRAME_LEN; i++) begin
            frame[i] = byte_t'($urandom);    // other nodes' slots
        end
        frame[`SYNC_CMD_ID_INDEX] = id;
        for (int i = 0; i < `SYNC_TIME_BYTES; i++) begin
            frame[`SYNC_TIME_INDEX + i] = stamp[8*i +: 8];
        end
        for (int i = 0; i < `SYNC_SLOT_BYTES; i++) begin
            frame[slot + i] = offs[8*i +: 8];
        end
        node_self = node;
        cmd_start = 1'b1;
        @(negedge clk);
        cmd_start  = 1'b0;
        cmd_setup  = 1'b1;
        cmd_enable = enable;
        @(negedge clk);
        cmd_setup = 1'b0;
        for (int i = 0; i < FRAME_LEN; i++) begin
            cmd_rx_index = IW'(i);
            cmd_rx_data  = frame[i];
            cmd_rx_valid = 1'b1;
            @(negedge clk);
        end
        cmd_rx_valid = 1'b0;
        cmd_fail     = fail;
        cmd_finish   = !fail;
        fix_now      = enable && !fail && id[0] && adj_enable;
        fix_renew    = id[1];
        fix_target   = stamp + time_t'(offs);
        @(negedge clk);
        cmd_finish = 1'b0;
        cmd_fail   = 1'b0;
        fix_now    = 1'b0;
        repeat (gap) @(negedge clk);
    endtask

    task automatic send_response(input byte_t node, input int gap);
        res_start = 1'b1;
        @(negedge clk);
        res_start = 1'b0;
        repeat (gap) @(negedge clk);
        res_setup  = 1'b1;
        res_enable = 1'b1;
        exp_slot   = slot_of(node);
        @(negedge clk);
        res_setup = 1'b0;
        for (int i = 0; i < FRAME_LEN; i++) begin
            res_rx_index = IW'(i);
            res_rx_valid = 1'b1;
            @(negedge clk);
        end
        res_rx_valid = 1'b0;
        repeat (4) @(negedge clk);
    endtask

    task automatic close_test(input string name);
        repeat (4) @(negedge clk);
        tests_run++;
        if (errors != errors_at_start) begin
            tests_failed++;
            $display("test %0d %s: failed", tests_run, name);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
        errors_at_start = errors;
    endtask

    initial begin
        offset_t offs;
        longint  delta;
        byte_t   node;
        void'($urandom(32'hab04));
        clk = 1'b0;
        reset = 1'b1;
        adj_enable = 1'b1;
        node_self = byte_t'(`SYNC_FIRST_NODE);
        adjust_min = offset_t'(-1000);
        adjust_max = offset_t'(1000);
        {cmd_start, cmd_setup, cmd_finish, cmd_fail, cmd_enable, cmd_rx_valid} = '0;
        cmd_rx_index = '0;
        cmd_rx_data = '0;
        {res_start, res_setup, res_enable, res_rx_valid} = '0;
        res_rx_index = '0;
        {fix_now, fix_renew, idle_check} = '0;
        fix_target = '0;
        exp_slot = '0;
        repeat (2) @(negedge clk);
        reset = 1'b0;

        idle_check = 1'b1;
        repeat (30) @(negedge clk);
        idle_check = 1'b0;
        close_test("free running tick");

        for (int i = 0; i < 4; i++) begin
            send_command(random_node(), 8'h03, {$urandom, $urandom}, $urandom, 1'b1, 1'b0, 10);
        end
        close_test("renew load");

        // even steps land inside the limits, odd ones outside
        for (int i = 0; i < 8; i++) begin
            if (i % 2 == 0) begin
                delta = longint'($urandom % 1600) - 800;
            end else begin
                delta = 2000 + longint'($urandom % 100000);
            end
            if (i % 4 == 3) delta = -delta;
            offs = $urandom % 65536;
            send_command(random_node(), 8'h01, m_time + time_t'(147 + delta) - time_t'(offs),
                         offs, 1'b1, 1'b0, 10);
        end
        close_test("clamped step");

        adj_enable = 1'b0;
        send_command(random_node(), 8'h03, {$urandom, $urandom}, $urandom, 1'b1, 1'b0, 10);
        adj_enable = 1'b1;
        send_command(random_node(), 8'h03, {$urandom, $urandom}, $urandom, 1'b1, 1'b1, 10);
        send_command(random_node(), 8'h03, {$urandom, $urandom}, $urandom, 1'b0, 1'b0, 10);
        send_command(random_node(), 8'h02, {$urandom, $urandom}, $urandom, 1'b1, 1'b0, 10);
        close_test("suppressed correction");

        for (int i = 0; i < 6; i++) begin
            node = random_node();
            send_command(node, byte_t'($urandom) & 8'hfe, {$urandom, $urandom}, $urandom,
                         1'b1, 1'b0, $urandom % 40);
            send_response(node, $urandom % 8);
        end
        close_test("response stamp");

        $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* synctimer_slave.f */
+incdir+include
source/synctimer_pkg.sv
source/packet_position.sv
source/field_capture.sv
source/sync_timer.sv
source/response_stamper.sv
source/synctimer_slave.sv
test/synctimer_slave_tb.sv

/* Bender.yml */
package:
  name: synctimer_slave

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/synctimer_pkg.sv
      - source/packet_position.sv
      - source/field_capture.sv
      - source/sync_timer.sv
      - source/response_stamper.sv
      - source/synctimer_slave.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/synctimer_slave_tb.sv
